// ==== hw/float_pkg.sv ====
// ----------------------------------------------------------------------
// Fixed-point to float conversion package
// Widths, single-precision format constants and the stream
// destination tag type shared by the converter data path
// ----------------------------------------------------------------------

package float_pkg;

    // ------------------------------------------------------------------
    // Stream widths
    // ------------------------------------------------------------------

    // Signed fixed-point input sample
    localparam int INPUT_WIDTH = 32;

    // Packed single-precision result
    localparam int FLOAT_WIDTH = 32;

    // ------------------------------------------------------------------
    // IEEE-754 single-precision format
    // ------------------------------------------------------------------

    localparam int MANTISSA_WIDTH = 23;
    localparam int EXPONENT_WIDTH = 8;
    localparam int EXPONENT_BIAS = 127;

    // Binary point position, Q16.15 input
    localparam int FRACTION_BITS = 15;

    // Converter latency, one cycle per stage
    localparam int PIPELINE_DEPTH = 3;

    // Leading-one index of a magnitude of INPUT_WIDTH+1 bits
    localparam int MSB_INDEX_WIDTH = $clog2(INPUT_WIDTH + 1);

    // Destination tag carried alongside each sample
    localparam int DEST_WIDTH = 8;

    typedef logic [DEST_WIDTH-1:0] dest_t;

endpackage

// ==== hw/sideband_delay.sv ====
// ----------------------------------------------------------------------
// Sideband delay line
// Fixed-depth register chain that keeps a payload in step with the
// converter pipeline, cleared to zero under reset
// ----------------------------------------------------------------------

module sideband_delay #(
    parameter type payload_t = logic,
    parameter int DEPTH = 3
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t data_in,
    output payload_t data_out
);

    // One register per pipeline stage
    payload_t stages [DEPTH];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= data_in;
            // Shift towards the output end
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // Last stage is the aligned output
    assign data_out = stages[DEPTH-1];

endmodule

// ==== hw/rounding_engine.sv ====
// ----------------------------------------------------------------------
// Round-to-nearest-even decision
// Looks at the bits dropped below the kept mantissa and tells
// stage 3 of the converter whether to add one ulp
// ----------------------------------------------------------------------

module rounding_engine (
    input  logic [float_pkg::INPUT_WIDTH:0]       magnitude,
    input  logic [float_pkg::MSB_INDEX_WIDTH-1:0] msb_index,
    input  logic                                  mantissa_lsb,
    output logic                                  round_up
);

    // Position of the first dropped bit
    int guard_pos;

    logic guard;
    logic sticky;

    always_comb begin
        guard_pos = 0;
        guard = 1'b0;
        sticky = 1'b0;

        // Bits are only dropped when the leading one sits above the
        // stored mantissa field
        if (int'(msb_index) > float_pkg::MANTISSA_WIDTH) begin
            guard_pos = int'(msb_index) - float_pkg::MANTISSA_WIDTH - 1;
            guard = magnitude[guard_pos];

            // Everything below the guard bit folds into sticky
            for (int i = 0; i < float_pkg::INPUT_WIDTH + 1; i++) begin
                if (i < guard_pos) begin
                    sticky = sticky | magnitude[i];
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Ties go to even
    // ------------------------------------------------------------------

    // Above half rounds up, exactly half rounds up only on odd mantissa
    assign round_up = guard & (sticky | mantissa_lsb);

endmodule

// ==== hw/fixed_to_float.sv ====
// ----------------------------------------------------------------------
// Fixed-point to single-precision float converter
// Three stages: sign and magnitude, leading-one search, then
// exponent, mantissa, round to nearest even and pack
// ----------------------------------------------------------------------

module fixed_to_float #(
    parameter int FRACTION_BITS = float_pkg::FRACTION_BITS
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [float_pkg::INPUT_WIDTH-1:0] in_data,
    input  logic                              in_valid,
    output logic [float_pkg::FLOAT_WIDTH-1:0] out_data,
    output logic                              out_valid
);

    // Priority search, highest set bit wins, zero gives index 0
    function automatic logic [float_pkg::MSB_INDEX_WIDTH-1:0] leading_one(
        input logic [float_pkg::INPUT_WIDTH:0] value
    );
        int index;
        index = 0;
        for (int i = 0; i < float_pkg::INPUT_WIDTH + 1; i++) begin
            if (value[i]) begin
                index = i;
            end
        end
        return index[float_pkg::MSB_INDEX_WIDTH-1:0];
    endfunction

    // ------------------------------------------------------------------
    // Stage 1: sign and absolute value
    // ------------------------------------------------------------------

    // One extra bit so that the most negative sample still fits
    logic [float_pkg::INPUT_WIDTH:0] extended;

    logic                            s1_valid;
    logic                            s1_sign;
    logic [float_pkg::INPUT_WIDTH:0] s1_abs;

    assign extended = {in_data[float_pkg::INPUT_WIDTH-1], in_data};

    always_ff @(posedge clock) begin
        if (!reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_sign <= in_data[float_pkg::INPUT_WIDTH-1];
        // Two's complement negate for negative samples
        if (in_data[float_pkg::INPUT_WIDTH-1]) begin
            s1_abs <= ~extended + 1'b1;
        end else begin
            s1_abs <= extended;
        end
    end

    // ------------------------------------------------------------------
    // Stage 2: leading-one detection
    // ------------------------------------------------------------------

    logic                                  s2_valid;
    logic                                  s2_sign;
    logic [float_pkg::INPUT_WIDTH:0]       s2_mag;
    logic [float_pkg::MSB_INDEX_WIDTH-1:0] s2_msb;

    always_ff @(posedge clock) begin
        if (!reset) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s2_sign <= s1_sign;
        s2_mag  <= s1_abs;
        s2_msb  <= leading_one(s1_abs);
    end

    // ------------------------------------------------------------------
    // Stage 3: exponent, mantissa, rounding and packing
    // ------------------------------------------------------------------

    int                                   exponent_full;
    logic [float_pkg::EXPONENT_WIDTH-1:0] exponent;
    logic [float_pkg::INPUT_WIDTH:0]      shifted;
    logic [float_pkg::MANTISSA_WIDTH-1:0] mantissa;
    logic                                 round_up;
    logic [float_pkg::FLOAT_WIDTH-2:0]    rounded_body;

    always_comb begin
        // Leading one at index n weighs 2^(n - FRACTION_BITS)
        exponent_full = float_pkg::EXPONENT_BIAS + int'(s2_msb) - FRACTION_BITS;
        exponent = exponent_full[float_pkg::EXPONENT_WIDTH-1:0];

        // Align the leading one to the hidden bit just above the field
        if (int'(s2_msb) < float_pkg::MANTISSA_WIDTH) begin
            shifted = s2_mag << (float_pkg::MANTISSA_WIDTH - int'(s2_msb));
        end else begin
            shifted = s2_mag >> (int'(s2_msb) - float_pkg::MANTISSA_WIDTH);
        end
        mantissa = shifted[float_pkg::MANTISSA_WIDTH-1:0];
    end

    rounding_engine rounder (
        .magnitude    (s2_mag),
        .msb_index    (s2_msb),
        .mantissa_lsb (mantissa[0]),
        .round_up     (round_up)
    );

    // Adding across exponent and mantissa together lets an all-ones
    // mantissa carry into the exponent and wrap to zero
    assign rounded_body = {exponent, mantissa}
                        + {{(float_pkg::FLOAT_WIDTH-2){1'b0}}, round_up};

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (s2_mag == '0) begin
            // Positive zero
            out_data <= '0;
        end else begin
            out_data <= {s2_sign, rounded_body};
        end
    end

endmodule

// ==== hw/stream_converter_top.sv ====
// ----------------------------------------------------------------------
// Stream converter top level
// Fixed-point sample stream in, single-precision float stream out,
// with last flag and destination tag kept aligned to their sample
// ----------------------------------------------------------------------

module stream_converter_top (
    input  logic                              clock,
    input  logic                              reset,

    // Sample stream from the source
    input  logic [float_pkg::INPUT_WIDTH-1:0] in_data,
    input  logic                              in_valid,
    input  logic                              in_last,
    input  float_pkg::dest_t                  in_dest,
    output logic                              in_ready,

    // Float stream towards the sink
    output logic [float_pkg::FLOAT_WIDTH-1:0] out_data,
    output logic                              out_valid,
    output logic                              out_last,
    output float_pkg::dest_t                  out_dest,
    input  logic                              out_ready
);

    // ------------------------------------------------------------------
    // Flow control
    // ------------------------------------------------------------------

    // No stall path, the source sees the sink's ready directly
    assign in_ready = out_ready;

    // ------------------------------------------------------------------
    // Data path
    // ------------------------------------------------------------------

    fixed_to_float #(
        .FRACTION_BITS (float_pkg::FRACTION_BITS)
    ) converter (
        .clock     (clock),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

    // ------------------------------------------------------------------
    // Sideband alignment
    // ------------------------------------------------------------------

    // Last flag, same latency as the converter
    sideband_delay #(
        .payload_t (logic),
        .DEPTH     (float_pkg::PIPELINE_DEPTH)
    ) last_delay (
        .clock    (clock),
        .reset    (reset),
        .data_in  (in_last),
        .data_out (out_last)
    );

    // Destination tag
    sideband_delay #(
        .payload_t (float_pkg::dest_t),
        .DEPTH     (float_pkg::PIPELINE_DEPTH)
    ) dest_delay (
        .clock    (clock),
        .reset    (reset),
        .data_in  (in_dest),
        .data_out (out_dest)
    );

endmodule

// ==== testbench/stream_converter_checker.sv ====
// ----------------------------------------------------------------------
// Stream converter assertions
// Reset state, ready pass-through and result timing of the top level
// ----------------------------------------------------------------------

module stream_converter_checker (
    input logic             clock,
    input logic             reset,
    input logic             in_valid,
    input logic             in_ready,
    input logic             out_ready,
    input logic             out_valid,
    input logic             out_last,
    input float_pkg::dest_t out_dest
);

    // Outputs clear while reset is low and in the first cycle after it
    reset_clears_outputs: assert property (
        @(posedge clock) !reset |=> (!out_valid && !out_last && out_dest == '0)
    ) else $error("stream outputs not cleared by reset");

    // No stall logic, ready goes straight through
    ready_follows_sink: assert property (
        @(posedge clock) in_ready == out_ready
    ) else $error("in_ready differs from out_ready");

    // One result per accepted sample, fixed latency
    valid_latency: assert property (
        @(posedge clock)
        (reset && $past(reset, 1) && $past(reset, 2) && $past(reset, 3))
        |-> out_valid == $past(in_valid, float_pkg::PIPELINE_DEPTH)
    ) else $error("out_valid does not match delayed in_valid");

endmodule

bind stream_converter_top stream_converter_checker checker_inst (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_dest  (out_dest)
);

// ==== testbench/tb_stream_converter.sv ====
// ----------------------------------------------------------------------
// Stream converter testbench
// Random fixed-point samples against a float reference model,
// scoreboard with latency and sideband checks
// ----------------------------------------------------------------------

module tb_stream_converter;

    localparam int NUM_CYCLES = 3000;
    localparam int DRAIN_LIMIT = 20;

    logic                              clock;
    logic                              reset;
    logic [float_pkg::INPUT_WIDTH-1:0] in_data;
    logic                              in_valid;
    logic                              in_last;
    float_pkg::dest_t                  in_dest;
    logic                              in_ready;
    logic [float_pkg::FLOAT_WIDTH-1:0] out_data;
    logic                              out_valid;
    logic                              out_last;
    float_pkg::dest_t                  out_dest;
    logic                              out_ready;

    // One scoreboard entry per accepted sample
    logic [31:0]      exp_data [$];
    logic             exp_last [$];
    float_pkg::dest_t exp_dest [$];
    int               exp_edge [$];

    int edge_count = 0;

    stream_converter_top dut (.*);

    always #50 clock = ~clock;

    always @(posedge clock) edge_count <= edge_count + 1;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("ERROR at time %0t: %s is %0h, expected %0h",
                                     $time, what, actual, expected));
        end
    endtask

    // Float value of sample / 2^15, rounded to nearest even
    function automatic logic [31:0] expected_float(input logic [31:0] sample);
        logic   sign;
        longint mag;
        int     idx;
        int     shift;
        longint mant;
        longint rem;
        longint half;
        longint body;
        sign = sample[31];
        mag = longint'($signed(sample));
        if (sign) begin
            mag = -mag;
        end
        if (mag == 0) begin
            return 32'h0;
        end
        idx = 0;
        while ((mag >> (idx + 1)) != 0) begin
            idx++;
        end
        body = longint'(127 + idx - 15) << 23;
        if (idx <= 23) begin
            mant = (mag << (23 - idx)) & 64'h7f_ffff;
        end else begin
            shift = idx - 23;
            mant = (mag >> shift) & 64'h7f_ffff;
            rem = mag & ((64'd1 << shift) - 1);
            half = 64'd1 << (shift - 1);
            // Round up above half, and at exactly half only to reach an even mantissa
            if (rem > half || (rem == half && (mant & 1) == 1)) begin
                body = body + 1;
            end
        end
        body = body + mant;
        return {sign, body[30:0]};
    endfunction

    // Sample mix biased towards edge cases of the conversion
    function automatic logic [31:0] random_sample();
        logic [31:0] value;
        int          idx;
        case ($urandom % 10)
            0: value = 32'h0;
            1: value = 32'h1;
            2: value = 32'hffff_ffff;
            3: value = 32'h8000_0000;
            4: value = $urandom | 32'h0100_0000;
            5: begin
                // Exact tie with the guard bit set and nothing below it
                idx = 24 + int'($urandom % 7);
                value = ($urandom & ((32'd1 << idx) - 1)) | (32'd1 << idx);
                value = (value & ~((32'd1 << (idx - 23)) - 1)) | (32'd1 << (idx - 24));
            end
            6: begin
                // All kept bits set so that rounding carries into the exponent
                idx = 24 + int'($urandom % 7);
                value = (32'd1 << (idx + 1)) - 1;
            end
            7: value = $urandom % 32'h0080_0000;
            default: value = $urandom;
        endcase
        if (value != 32'h8000_0000 && ($urandom % 2) == 1) begin
            value = -value;
        end
        return value;
    endfunction

    // ------------------------------------------------------------------
    // Scoreboard
    // ------------------------------------------------------------------

    always @(negedge clock) begin
        if (reset) begin
            check_value("in_ready", in_ready, out_ready);
            if (out_valid) begin
                if (exp_data.size() == 0) begin
                    report_failure("A result came out with no sample in flight");
                end else begin
                    check_value("out_data", out_data, exp_data.pop_front());
                    check_value("out_last", out_last, exp_last.pop_front());
                    check_value("out_dest", out_dest, exp_dest.pop_front());
                    // The sink takes the result at the coming rising edge
                    check_value("latency", edge_count + 1 - exp_edge.pop_front(),
                                float_pkg::PIPELINE_DEPTH);
                end
            end
            // Sample is taken at the coming rising edge
            if (in_valid) begin
                exp_data.push_back(expected_float(in_data));
                exp_last.push_back(in_last);
                exp_dest.push_back(in_dest);
                exp_edge.push_back(edge_count + 1);
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    initial begin
        int low_cycles;
        int waited;
        clock = 1'b0;
        reset = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        in_last = 1'b0;
        in_dest = '0;
        out_ready = 1'b1;
        low_cycles = 0;
        void'($urandom(32'h2cd5074e));

        // Known values of the model
        check_value("model of 1.0", expected_float(32'h0000_8000), 32'h3f80_0000);
        check_value("model of -65536.0", expected_float(32'h8000_0000), 32'hc780_0000);

        repeat (2) @(posedge clock);
        #5;
        reset = 1'b1;

        @(negedge clock);
        check_value("out_valid after reset", out_valid, 1'b0);
        check_value("out_last after reset", out_last, 1'b0);
        check_value("out_dest after reset", out_dest, '0);

        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            @(posedge clock);
            #5;
            in_last = 1'($urandom % 2);
            in_dest = float_pkg::dest_t'($urandom);
            if (low_cycles == 0 && ($urandom % 16) == 0) begin
                low_cycles = 1 + int'($urandom % 4);
            end
            if (low_cycles > 0) begin
                // Source holds off while the sink is not ready
                low_cycles--;
                out_ready = 1'b0;
                in_valid = 1'b0;
            end else begin
                out_ready = 1'b1;
                in_valid = ($urandom % 5) != 0;
                in_data = random_sample();
            end
        end

        @(posedge clock);
        #5;
        in_valid = 1'b0;
        out_ready = 1'b1;

        waited = 0;
        while (exp_data.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (exp_data.size() != 0) begin
            report_failure("Timeout while waiting for the last results to come out");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== project.f ====
hw/float_pkg.sv
hw/sideband_delay.sv
hw/rounding_engine.sv
hw/fixed_to_float.sv
hw/stream_converter_top.sv
testbench/stream_converter_checker.sv
testbench/tb_stream_converter.sv

// ==== Makefile ====
# Verilator build and run of the stream converter testbench

TOP = tb_stream_converter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		-f project.f --top-module $(TOP) -o sim

run: compile
	-./obj_dir/sim > sim.log 2>&1
	cat sim.log
	@if grep -q "CHECKS FAILED" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" sim.log; then \
		echo "Simulation ended without passing"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
